/* source/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DATA_W      32
`define REG_AW      5

// Word index comes from address bits 9 down to 2
`define DMEM_WORDS  256

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CTRL_OFS    4'h0
`define STATUS_OFS  4'h4
`define EPC_OFS     4'h8

`endif

/* source/pipe_pkg.sv */
package pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDI    = 6'h08,
        ADDIU   = 6'h09,
        ANDI    = 6'h0C,
        ORI     = 6'h0D,
        LW      = 6'h23,
        SW      = 6'h2B
    } opcode_e;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2A
    } funct_e;

    // The same 32-bit word seen as R-type or I-type
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_e     funct;
        } r;
        struct packed {
            opcode_e     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    // Cause codes follow the MIPS ExcCode numbering
    typedef enum logic [4:0] {
        NONE = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        RI   = 5'd10,
        OV   = 5'd12
    } cause_e;

endpackage

/* source/ex_stage.sv */
`include "pipe_defines.svh"

module ex_stage import pipe_pkg::*; (
    input  logic               valid,
    input  instr_u             instruction,
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    output logic [`DATA_W-1:0] alu_result,
    output logic [`DATA_W-1:0] store_data,
    output logic [`REG_AW-1:0] dest_addr,
    output logic               reg_write,
    output logic               mem_write,
    output logic               mem_to_reg,
    output logic               except_valid,
    output cause_e             except_cause
);

    localparam int MSB = `DATA_W - 1;

    logic               is_rtype;
    logic [`DATA_W-1:0] imm_sext;
    logic [`DATA_W-1:0] imm_zext;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic               add_ovf;
    logic               sub_ovf;
    logic               misaligned;
    logic [`DATA_W-1:0] result;
    logic               wr_en;
    logic               st_en;
    logic               ld_en;
    logic               fault;
    cause_e             cause;

    assign is_rtype = (instruction.r.opcode == SPECIAL);
    assign imm_sext = {{(`DATA_W-16){instruction.i.imm[15]}}, instruction.i.imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, instruction.i.imm};

    // One adder serves ADD, ADDI and the load/store address
    assign op_b = is_rtype ? rt_data : imm_sext;
    assign sum  = rs_data + op_b;
    assign diff = rs_data - rt_data;

    assign add_ovf    = (rs_data[MSB] == op_b[MSB]) && (sum[MSB] != rs_data[MSB]);
    assign sub_ovf    = (rs_data[MSB] != rt_data[MSB]) && (diff[MSB] != rs_data[MSB]);
    assign misaligned = (sum[1:0] != 2'b00);

    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        st_en  = 1'b0;
        ld_en  = 1'b0;
        cause  = NONE;
        case (instruction.r.opcode)
            SPECIAL: begin
                wr_en = 1'b1;
                case (instruction.r.funct)
                    ADD: begin
                        result = sum;
                        if (add_ovf) cause = OV;
                    end
                    ADDU: result = sum;
                    SUB: begin
                        result = diff;
                        if (sub_ovf) cause = OV;
                    end
                    SUBU: result = diff;
                    AND:  result = rs_data & rt_data;
                    OR:   result = rs_data | rt_data;
                    XOR:  result = rs_data ^ rt_data;
                    SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(rs_data) < $signed(rt_data)};
                    default: begin
                        wr_en = 1'b0;
                        cause = RI;
                    end
                endcase
            end
            ADDI: begin
                result = sum;
                wr_en  = 1'b1;
                if (add_ovf) cause = OV;
            end
            ADDIU: begin
                result = sum;
                wr_en  = 1'b1;
            end
            ANDI: begin
                result = rs_data & imm_zext;
                wr_en  = 1'b1;
            end
            ORI: begin
                result = rs_data | imm_zext;
                wr_en  = 1'b1;
            end
            LW: begin
                result = sum;
                wr_en  = 1'b1;
                ld_en  = 1'b1;
                if (misaligned) cause = ADEL;
            end
            SW: begin
                result = sum;
                st_en  = 1'b1;
                if (misaligned) cause = ADES;
            end
            default: cause = RI;
        endcase
    end

    assign fault        = (cause != NONE);
    assign except_valid = valid && fault;
    assign except_cause = except_valid ? cause : NONE;

    assign alu_result = result;
    assign store_data = rt_data;
    assign dest_addr  = is_rtype ? instruction.r.rd : instruction.r.rt;

    // Register 0 is hardwired, so a write there is dropped here
    assign reg_write  = valid && !fault && wr_en && (dest_addr != '0);
    assign mem_write  = valid && !fault && st_en;
    assign mem_to_reg = valid && !fault && ld_en;

    // Upstream presents a fully known instruction word whenever valid is high
    always_comb begin
        assert final (!valid || !$isunknown(instruction));
    end

endmodule

/* source/ex_mem_regs.sv */
`include "pipe_defines.svh"

module ex_mem_regs import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  logic               except_clear,

    input  instr_u             ex_instruction,
    input  logic               ex_reg_write,
    input  logic               ex_mem_write,
    input  logic               ex_mem_to_reg,
    input  logic [`REG_AW-1:0] ex_dest_addr,
    input  logic [`DATA_W-1:0] ex_alu_result,
    input  logic [`DATA_W-1:0] ex_store_data,

    output instr_u             mem_instruction,
    output logic               mem_reg_write,
    output logic               mem_mem_write,
    output logic               mem_mem_to_reg,
    output logic [`REG_AW-1:0] mem_dest_addr,
    output logic [`DATA_W-1:0] mem_alu_result,
    output logic [`DATA_W-1:0] mem_store_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_instruction <= '0;
            mem_reg_write   <= 1'b0;
            mem_mem_write   <= 1'b0;
            mem_mem_to_reg  <= 1'b0;
            mem_dest_addr   <= '0;
            mem_alu_result  <= '0;
            mem_store_data  <= '0;
        end else if (cpu_en) begin
            if (except_clear) begin
                // The faulting instruction becomes a bubble
                mem_instruction <= '0;
                mem_reg_write   <= 1'b0;
                mem_mem_write   <= 1'b0;
                mem_mem_to_reg  <= 1'b0;
                mem_dest_addr   <= '0;
                mem_alu_result  <= '0;
                mem_store_data  <= '0;
            end else begin
                mem_instruction <= ex_instruction;
                mem_reg_write   <= ex_reg_write;
                mem_mem_write   <= ex_mem_write;
                mem_mem_to_reg  <= ex_mem_to_reg;
                mem_dest_addr   <= ex_dest_addr;
                mem_alu_result  <= ex_alu_result;
                mem_store_data  <= ex_store_data;
            end
        end
        // With cpu_en low everything holds
    end

    // Execute has already dropped the control bits of a faulting instruction
    assert property (@(posedge clk) disable iff (rst)
        except_clear |-> !(ex_reg_write || ex_mem_write || ex_mem_to_reg));

endmodule

/* source/mem_stage.sv */
`include "pipe_defines.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,

    input  logic               mem_reg_write,
    input  logic               mem_mem_write,
    input  logic               mem_mem_to_reg,
    input  logic [`REG_AW-1:0] mem_dest_addr,
    input  logic [`DATA_W-1:0] mem_alu_result,
    input  logic [`DATA_W-1:0] mem_store_data,

    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_addr,
    output logic [`DATA_W-1:0] wb_data
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
    logic [IDX_W-1:0]   word_idx;
    logic [`DATA_W-1:0] rd_data;
    logic [`DATA_W-1:0] wb_alu_result;
    logic               wb_mem_to_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Upper address bits alias onto the same words
    assign word_idx = mem_alu_result[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            if (mem_mem_write) begin
                dmem[word_idx] <= mem_store_data;
            end
            rd_data <= dmem[word_idx];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM/WB register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we         <= 1'b0;
            wb_addr       <= '0;
            wb_alu_result <= '0;
            wb_mem_to_reg <= 1'b0;
        end else if (cpu_en) begin
            wb_we         <= mem_reg_write;
            wb_addr       <= mem_dest_addr;
            wb_alu_result <= mem_alu_result;
            wb_mem_to_reg <= mem_mem_to_reg;
        end else begin
            // Held contents stay, but the write pulse is not repeated
            wb_we <= 1'b0;
        end
    end

    assign wb_data = wb_mem_to_reg ? rd_data : wb_alu_result;

    // Register 0 writes are filtered back in execute
    assert property (@(posedge clk) disable iff (rst) wb_we |-> (wb_addr != '0));

endmodule

/* source/pipe_ctrl_regs.sv */
`include "pipe_defines.svh"

module pipe_ctrl_regs import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    input  logic [3:0]         paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`DATA_W-1:0] pwdata,
    output logic [`DATA_W-1:0] prdata,
    output logic               pready,
    output logic               pslverr,

    input  logic               except_valid,
    input  cause_e             except_cause,
    input  logic [`DATA_W-1:0] except_pc,

    output logic               cpu_en
);

    logic               setup;
    logic               wr_access;
    logic               mapped;
    logic               hw_capture;
    logic               pending;
    cause_e             cause;
    logic [`DATA_W-1:0] epc;
    logic [`DATA_W-1:0] rd_mux;

    assign setup      = psel && !penable;
    assign wr_access  = psel && penable && pwrite;
    assign hw_capture = except_valid && cpu_en;

    assign mapped = (paddr == `CTRL_OFS) || (paddr == `STATUS_OFS) || (paddr == `EPC_OFS);

    // Zero wait states on every transfer
    assign pready = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control and status state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_en  <= 1'b0;
            pending <= 1'b0;
            cause   <= NONE;
            epc     <= '0;
        end else if (hw_capture) begin
            // An exception beats any software write on the same edge
            cpu_en  <= 1'b0;
            pending <= 1'b1;
            cause   <= except_cause;
            epc     <= except_pc;
        end else if (wr_access) begin
            case (paddr)
                `CTRL_OFS: cpu_en <= pwdata[0];
                `STATUS_OFS: begin
                    if (pwdata[0]) begin
                        pending <= 1'b0;
                        cause   <= NONE;
                    end
                end
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (paddr)
            `CTRL_OFS:   rd_mux = {{(`DATA_W-1){1'b0}}, cpu_en};
            `STATUS_OFS: rd_mux = {{(`DATA_W-7){1'b0}}, cause, 1'b0, pending};
            `EPC_OFS:    rd_mux = epc;
            default:     rd_mux = '0;
        endcase
    end

    // Captured in the setup phase so the access phase sees it directly
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            prdata  <= (setup && !pwrite) ? rd_mux : '0;
            pslverr <= setup && !mapped;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pslverr |-> (psel && penable));

endmodule

/* source/ex_mem_wb_top.sv */
`include "pipe_defines.svh"

module ex_mem_wb_top import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    input  logic [3:0]         paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`DATA_W-1:0] pwdata,
    output logic [`DATA_W-1:0] prdata,
    output logic               pready,
    output logic               pslverr,

    input  logic               ex_valid,
    input  instr_u             ex_instruction,
    input  logic [`DATA_W-1:0] ex_pc,
    input  logic [`DATA_W-1:0] ex_rs_data,
    input  logic [`DATA_W-1:0] ex_rt_data,
    output logic               ex_ready,

    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_addr,
    output logic [`DATA_W-1:0] wb_data
);

    logic               cpu_en;
    logic [`DATA_W-1:0] ex_alu_result;
    logic [`DATA_W-1:0] ex_store_data;
    logic [`REG_AW-1:0] ex_dest_addr;
    logic               ex_reg_write;
    logic               ex_mem_write;
    logic               ex_mem_to_reg;
    logic               except_valid;
    cause_e             except_cause;
    logic               mem_reg_write;
    logic               mem_mem_write;
    logic               mem_mem_to_reg;
    logic [`REG_AW-1:0] mem_dest_addr;
    logic [`DATA_W-1:0] mem_alu_result;
    logic [`DATA_W-1:0] mem_store_data;

    assign ex_ready = cpu_en;

    ex_stage u_ex_stage (
        .valid        (ex_valid),
        .instruction  (ex_instruction),
        .rs_data      (ex_rs_data),
        .rt_data      (ex_rt_data),
        .alu_result   (ex_alu_result),
        .store_data   (ex_store_data),
        .dest_addr    (ex_dest_addr),
        .reg_write    (ex_reg_write),
        .mem_write    (ex_mem_write),
        .mem_to_reg   (ex_mem_to_reg),
        .except_valid (except_valid),
        .except_cause (except_cause)
    );

    // The traced instruction word is left for waveform viewing
    ex_mem_regs u_ex_mem_regs (
        .clk             (clk),
        .rst             (rst),
        .cpu_en          (cpu_en),
        .except_clear    (except_valid),
        .ex_instruction  (ex_instruction),
        .ex_reg_write    (ex_reg_write),
        .ex_mem_write    (ex_mem_write),
        .ex_mem_to_reg   (ex_mem_to_reg),
        .ex_dest_addr    (ex_dest_addr),
        .ex_alu_result   (ex_alu_result),
        .ex_store_data   (ex_store_data),
        .mem_instruction (),
        .mem_reg_write   (mem_reg_write),
        .mem_mem_write   (mem_mem_write),
        .mem_mem_to_reg  (mem_mem_to_reg),
        .mem_dest_addr   (mem_dest_addr),
        .mem_alu_result  (mem_alu_result),
        .mem_store_data  (mem_store_data)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst            (rst),
        .cpu_en         (cpu_en),
        .mem_reg_write  (mem_reg_write),
        .mem_mem_write  (mem_mem_write),
        .mem_mem_to_reg (mem_mem_to_reg),
        .mem_dest_addr  (mem_dest_addr),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .wb_we          (wb_we),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

    pipe_ctrl_regs u_pipe_ctrl_regs (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .except_valid (except_valid),
        .except_cause (except_cause),
        .except_pc    (ex_pc),
        .cpu_en       (cpu_en)
    );

endmodule

/* test/tb_ex_mem_wb.sv */
`include "pipe_defines.svh"

module tb_ex_mem_wb import pipe_pkg::*; ();

    localparam logic [31:0] SEED        = 32'ha84fa83e;
    localparam int          N_ALU       = 40;
    localparam int          N_MEM       = 16;
    localparam int          N_FAULT     = 4;
    localparam int          READY_LIMIT = 20;
    localparam int          DRAIN_LIMIT = 20;
    // Reset, one cycle per instruction with slack, and roughly 60 cycles per fault case
    localparam int TIMEOUT_CYCLES = 16 + 4 * (N_ALU + 2 * N_MEM) + 60 * N_FAULT + 100;

    localparam logic [47:0] R_FUNCTS = {SLT, XOR, OR, AND, SUBU, SUB, ADDU, ADD};
    localparam logic [23:0] I_OPS    = {ORI, ANDI, ADDIU, ADDI};

    logic               clk = 1'b0;
    logic               rst;
    logic [3:0]         paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`DATA_W-1:0] pwdata;
    logic [`DATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               ex_valid;
    instr_u             ex_instruction;
    logic [`DATA_W-1:0] ex_pc;
    logic [`DATA_W-1:0] ex_rs_data;
    logic [`DATA_W-1:0] ex_rt_data;
    logic               ex_ready;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_addr;
    logic [`DATA_W-1:0] wb_data;

    int                 cycle_cnt = 0;
    int                 n_checks  = 0;
    int                 n_errors  = 0;
    logic [`DATA_W-1:0] next_pc   = 32'h0040_0000;
    logic [`DATA_W-1:0] model_mem [`DMEM_WORDS];
    logic [`REG_AW-1:0] exp_addr_q [$];
    logic [`DATA_W-1:0] exp_data_q [$];
    int                 exp_cycle_q [$];
    logic [`DATA_W-1:0] base_arr [N_MEM];
    logic [15:0]        offs_arr [N_MEM];

    ex_mem_wb_top dut (
        .clk            (clk),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .ex_valid       (ex_valid),
        .ex_instruction (ex_instruction),
        .ex_pc          (ex_pc),
        .ex_rs_data     (ex_rs_data),
        .ex_rt_data     (ex_rt_data),
        .ex_ready       (ex_ready),
        .wb_we          (wb_we),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Run stopped at cycle %0d before the tests finished", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp)
        else begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (n_errors == err_mark)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, n_errors - err_mark);
    endtask

    // Every write-back pulse must match the oldest outstanding prediction
    always @(negedge clk) begin
        if (!rst && wb_we) begin
            n_checks++;
            assert (exp_addr_q.size() != 0)
            else begin
                $display("Write-back to register %0d arrived with nothing expected", wb_addr);
                n_errors++;
            end
            if (exp_addr_q.size() != 0) begin
                check_value("wb_addr", wb_addr, exp_addr_q.pop_front());
                check_value("wb_data", wb_data, exp_data_q.pop_front());
                check_value("wb cycle", cycle_cnt, exp_cycle_q.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic out_of_range(input longint v);
        return (v > 64'sd2147483647) || (v < -64'sd2147483648);
    endfunction

    function automatic void predict_instr(
        input  logic [31:0] instr,
        input  logic [31:0] rs_val,
        input  logic [31:0] rt_val,
        output logic        exp_we,
        output logic [4:0]  exp_addr,
        output logic [31:0] exp_data,
        output logic        exp_store,
        output logic [7:0]  exp_idx,
        output logic [31:0] exp_word,
        output cause_e      exp_cause
    );
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] sext;
        logic [31:0] addr;
        longint      srs;
        longint      srt;
        longint      ssext;
        logic        writes;
        op        = instr[31:26];
        fn        = instr[5:0];
        sext      = {{16{instr[15]}}, instr[15:0]};
        addr      = rs_val + sext;
        srs       = longint'($signed(rs_val));
        srt       = longint'($signed(rt_val));
        ssext     = longint'($signed(sext));
        writes    = 1'b1;
        exp_data  = '0;
        exp_store = 1'b0;
        exp_idx   = addr[9:2];
        exp_word  = rt_val;
        exp_cause = NONE;
        exp_addr  = (op == SPECIAL) ? instr[15:11] : instr[20:16];
        case (op)
            SPECIAL: begin
                case (fn)
                    ADD, ADDU: begin
                        exp_data = rs_val + rt_val;
                        if (fn == ADD && out_of_range(srs + srt)) exp_cause = OV;
                    end
                    SUB, SUBU: begin
                        exp_data = rs_val - rt_val;
                        if (fn == SUB && out_of_range(srs - srt)) exp_cause = OV;
                    end
                    AND:     exp_data = rs_val & rt_val;
                    OR:      exp_data = rs_val | rt_val;
                    XOR:     exp_data = rs_val ^ rt_val;
                    SLT:     exp_data = (srs < srt) ? 32'd1 : 32'd0;
                    default: exp_cause = RI;
                endcase
            end
            ADDI, ADDIU: begin
                exp_data = addr;
                if (op == ADDI && out_of_range(srs + ssext)) exp_cause = OV;
            end
            ANDI: exp_data = rs_val & {16'h0, instr[15:0]};
            ORI:  exp_data = rs_val | {16'h0, instr[15:0]};
            LW: begin
                if (addr[1:0] != 2'b00) exp_cause = ADEL;
                else exp_data = model_mem[addr[9:2]];
            end
            SW: begin
                writes    = 1'b0;
                exp_store = (addr[1:0] == 2'b00);
                if (!exp_store) exp_cause = ADES;
            end
            default: exp_cause = RI;
        endcase
        if (exp_cause != NONE) begin
            writes    = 1'b0;
            exp_store = 1'b0;
        end
        exp_we = writes && (exp_addr != 5'd0);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // Read data and error were registered in setup and hold for the access phase
        data = prdata;
        err  = pslverr;
        check_value("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drive_instr(input logic [31:0] instr, input logic [31:0] rs_val,
                               input logic [31:0] rt_val, output logic [31:0] pc,
                               output cause_e cause);
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        st;
        logic [7:0]  idx;
        logic [31:0] word;
        int          waited;
        waited = 0;
        pc     = next_pc;
        cause  = NONE;
        @(negedge clk);
        ex_valid = 1'b0;
        while (!ex_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        n_checks++;
        assert (ex_ready)
        else begin
            $display("Pipeline never became ready for the instruction at pc 0x%h", pc);
            n_errors++;
        end
        if (ex_ready) begin
            predict_instr(instr, rs_val, rt_val, we, addr, data, st, idx, word, cause);
            if (we) begin
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(data);
                exp_cycle_q.push_back(cycle_cnt + 2);
            end
            if (st) model_mem[idx] = word;
            ex_valid       = 1'b1;
            ex_instruction = instr;
            ex_pc          = pc;
            ex_rs_data     = rs_val;
            ex_rt_data     = rt_val;
            next_pc        = next_pc + 4;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        ex_valid = 1'b0;
    endtask

    task automatic wait_writebacks();
        int n;
        n = 0;
        while (exp_addr_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        n_checks++;
        assert (exp_addr_q.size() == 0)
        else begin
            $display("%0d expected write-backs never arrived", exp_addr_q.size());
            n_errors++;
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_cycle_q.delete();
        end
    endtask

    function automatic logic [31:0] random_alu_instr();
        int          sel;
        logic [4:0]  rs_f;
        logic [4:0]  rt_f;
        logic [4:0]  rd_f;
        logic [15:0] imm;
        sel  = $urandom_range(0, 11);
        rs_f = 5'($urandom);
        rt_f = 5'($urandom);
        rd_f = 5'($urandom);
        imm  = 16'($urandom);
        // Now and then aim at register 0 so that dropped writes get exercised
        if ($urandom_range(0, 7) == 0) begin
            rt_f = 5'd0;
            rd_f = 5'd0;
        end
        if (sel < 8)
            return {SPECIAL, rs_f, rt_f, rd_f, 5'd0, R_FUNCTS[sel*6 +: 6]};
        return {I_OPS[(sel-8)*6 +: 6], rs_f, rt_f, imm};
    endfunction

    task automatic drive_random_alu();
        logic [31:0] instr;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] pc;
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        st;
        logic [7:0]  idx;
        logic [31:0] word;
        cause_e      cause;
        do begin
            instr  = random_alu_instr();
            rs_val = $urandom;
            rt_val = $urandom;
            predict_instr(instr, rs_val, rt_val, we, addr, data, st, idx, word, cause);
        end while (cause != NONE);
        drive_instr(instr, rs_val, rt_val, pc, cause);
    endtask

    task automatic fault_and_recover(input logic [31:0] instr, input logic [31:0] rs_val,
                                     input logic [31:0] rt_val);
        logic [31:0] pc;
        logic [31:0] rdata;
        logic        err;
        cause_e      cause;
        drive_instr(instr, rs_val, rt_val, pc, cause);
        go_idle();
        wait_writebacks();
        check_value("ex_ready", ex_ready, 1'b0);
        apb_read(`STATUS_OFS, rdata, err);
        check_value("status", rdata, {25'd0, cause, 1'b0, 1'b1});
        apb_read(`EPC_OFS, rdata, err);
        check_value("epc", rdata, pc);
        apb_write(`STATUS_OFS, 32'h1);
        apb_write(`CTRL_OFS, 32'h1);
        apb_read(`STATUS_OFS, rdata, err);
        check_value("status", rdata, 32'h0);
        check_value("ex_ready", ex_ready, 1'b1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          err_mark;
        int          i;
        logic [31:0] rdata;
        logic [31:0] pc;
        logic [31:0] base;
        logic [31:0] stored;
        logic        err;
        cause_e      cause;
        void'($urandom(SEED));
        rst            = 1'b1;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        ex_valid       = 1'b0;
        ex_instruction = '0;
        ex_pc          = '0;
        ex_rs_data     = '0;
        ex_rt_data     = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        err_mark = n_errors;
        @(negedge clk);
        check_value("ex_ready", ex_ready, 1'b0);
        check_value("wb_we", wb_we, 1'b0);
        apb_read(`CTRL_OFS, rdata, err);
        check_value("prdata", rdata, 32'h0);
        check_value("pslverr", err, 1'b0);
        apb_write(`CTRL_OFS, 32'h1);
        check_value("ex_ready", ex_ready, 1'b1);
        report_test("reset and run", err_mark);

        err_mark = n_errors;
        for (i = 0; i < N_ALU; i++) begin
            drive_random_alu();
        end
        go_idle();
        wait_writebacks();
        report_test("random ALU", err_mark);

        err_mark = n_errors;
        for (i = 0; i < N_MEM; i++) begin
            base_arr[i] = $urandom & ~32'h3;
            offs_arr[i] = 16'($urandom) & 16'hfffc;
            drive_instr({SW, 5'd3, 5'd4, offs_arr[i]}, base_arr[i], $urandom, pc, cause);
        end
        for (i = 0; i < N_MEM; i++) begin
            drive_instr({LW, 5'd3, 5'($urandom_range(1, 31)), offs_arr[i]}, base_arr[i],
                        32'h0, pc, cause);
        end
        go_idle();
        wait_writebacks();
        report_test("store then load", err_mark);

        err_mark = n_errors;
        drive_random_alu();
        fault_and_recover({SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, ADD},
                          32'h7000_0000 | ($urandom & 32'h00ff_ffff),
                          32'h4000_0000 | ($urandom & 32'h00ff_ffff));
        drive_random_alu();
        fault_and_recover({LW, 5'd1, 5'd5, 16'h0}, ($urandom & ~32'h3) | 32'h1, 32'h0);
        drive_random_alu();
        fault_and_recover({SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, $urandom, $urandom);
        drive_random_alu();
        go_idle();
        wait_writebacks();
        report_test("exceptions", err_mark);

        err_mark = n_errors;
        base   = $urandom & ~32'h3;
        stored = $urandom;
        drive_instr({SW, 5'd3, 5'd4, 16'h0}, base, stored, pc, cause);
        fault_and_recover({SW, 5'd3, 5'd4, 16'h2}, base, ~stored);
        drive_instr({LW, 5'd3, 5'd9, 16'h0}, base, 32'h0, pc, cause);
        go_idle();
        wait_writebacks();
        apb_read(4'hc, rdata, err);
        check_value("pslverr", err, 1'b1);
        report_test("misaligned store", err_mark);

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+source
source/pipe_pkg.sv
source/ex_stage.sv
source/ex_mem_regs.sv
source/mem_stage.sv
source/pipe_ctrl_regs.sv
source/ex_mem_wb_top.sv
test/tb_ex_mem_wb.sv

/* Bender.yml */
package:
  name: ex_mem_wb

sources:
  - include_dirs:
      - source
    files:
      - source/pipe_pkg.sv
      - source/ex_stage.sv
      - source/ex_mem_regs.sv
      - source/mem_stage.sv
      - source/pipe_ctrl_regs.sv
      - source/ex_mem_wb_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_ex_mem_wb.sv
